// ==== verilog/nes_host_pkg.sv ====
// NES host glue shared definitions
// widths, host UART register map, DualShock bit positions,
// NES frame phase count and the host register byte layout

package nes_host_pkg;

  localparam int BYTE_W = 8;
  localparam int ADDR_W = 22;  // 4 MB memory space

  // host UART register addresses
  localparam logic [7:0] LOADER_CONF_ADDR = 8'h35;  // loader config, bit 0 = reset
  localparam logic [7:0] LOADER_DATA_ADDR = 8'h37;  // ROM byte stream
  localparam logic [7:0] PAD1_BTN_ADDR    = 8'h40;
  localparam logic [7:0] PAD2_BTN_ADDR    = 8'h41;

  // DualShock receive byte 0: L D R U St R3 L3 Se
  localparam int DS2_LEFT   = 7;
  localparam int DS2_DOWN   = 6;
  localparam int DS2_RIGHT  = 5;
  localparam int DS2_UP     = 4;
  localparam int DS2_START  = 3;
  localparam int DS2_SELECT = 0;

  // DualShock receive byte 1: Sq X O Tr R1 L1 R2 L2
  localparam int DS2_CROSS  = 6;  // becomes NES B
  localparam int DS2_CIRCLE = 5;  // becomes NES A

  // clk cycles per NES frame slot
  localparam int NES_CE_PHASES = 5;

  // one host register byte, read as buttons or as loader config
  typedef union packed {
    struct packed {
      logic right;
      logic left;
      logic down;
      logic up;
      logic start;
      logic select;
      logic b;
      logic a;
    } btn;
    struct packed {
      logic [6:0] rsvd;
      logic       loader_rst;
    } conf;
  } host_reg_u;

endpackage

// ==== verilog/host_reg_decode.sv ====
// Host register decode
// captures UART register writes into the loader config and the
// host-forced button bytes, and picks the loader byte source

`timescale 1ns/1ns

module host_reg_decode (
  input  logic                            clk,
  input  logic                            sys_resetn,
  input  logic [7:0]                      uart_addr,
  input  logic [nes_host_pkg::BYTE_W-1:0] uart_data,
  input  logic                            uart_write,
  input  logic [nes_host_pkg::BYTE_W-1:0] sd_dout,
  input  logic                            sd_dout_valid,
  output logic [nes_host_pkg::BYTE_W-1:0] loader_input,
  output logic                            loader_clk,
  output logic                            loader_reset,
  output logic [nes_host_pkg::BYTE_W-1:0] host_btn1,
  output logic [nes_host_pkg::BYTE_W-1:0] host_btn2
);

  nes_host_pkg::host_reg_u conf_reg;
  nes_host_pkg::host_reg_u pad1_reg;
  nes_host_pkg::host_reg_u pad2_reg;

  logic conf_hit;
  logic data_hit;
  logic pad1_hit;
  logic pad2_hit;

  // address match, qualified by the write strobe
  assign conf_hit = uart_write && (uart_addr == nes_host_pkg::LOADER_CONF_ADDR);
  assign data_hit = uart_write && (uart_addr == nes_host_pkg::LOADER_DATA_ADDR);
  assign pad1_hit = uart_write && (uart_addr == nes_host_pkg::PAD1_BTN_ADDR);
  assign pad2_hit = uart_write && (uart_addr == nes_host_pkg::PAD2_BTN_ADDR);

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      conf_reg <= '0;
      pad1_reg <= '0;
      pad2_reg <= '0;
    end else begin
      if (conf_hit) begin
        conf_reg <= uart_data;
      end
      if (pad1_hit) begin
        pad1_reg <= uart_data;
      end
      if (pad2_hit) begin
        pad2_reg <= uart_data;
      end
    end
  end

  // SD card has priority over the UART stream
  always_comb begin
    if (sd_dout_valid) begin
      loader_input = sd_dout;
    end else begin
      loader_input = uart_data;
    end
  end

  assign loader_clk = data_hit || sd_dout_valid;  // one strobe per ROM byte

  // loader held in reset by system reset or by host
  assign loader_reset = !sys_resetn || conf_reg.conf.loader_rst;

  assign host_btn1 = pad1_reg.btn;  // already in NES order
  assign host_btn2 = pad2_reg.btn;

endmodule

// ==== verilog/joypad_port.sv ====
// NES joypad port
// maps one DualShock to NES button order, merges the host buttons
// and shifts the byte out to the NES core, LSB first

`timescale 1ns/1ns

module joypad_port (
  input  logic                            clk,
  input  logic                            sys_resetn,
  input  logic [nes_host_pkg::BYTE_W-1:0] ds2_byte0,
  input  logic [nes_host_pkg::BYTE_W-1:0] ds2_byte1,
  input  logic [nes_host_pkg::BYTE_W-1:0] host_btn,
  input  logic                            joypad_strobe,
  input  logic                            joypad_clock,
  output logic                            joypad_data
);

  logic [nes_host_pkg::BYTE_W-1:0] pad_btn;
  logic [nes_host_pkg::BYTE_W-1:0] shift_reg;
  logic                            last_clock;
  logic                            clock_fall;

  // DualShock bits are active low
  // NES order: R L D U START SELECT B A
  assign pad_btn = {
    ~ds2_byte0[nes_host_pkg::DS2_RIGHT],
    ~ds2_byte0[nes_host_pkg::DS2_LEFT],
    ~ds2_byte0[nes_host_pkg::DS2_DOWN],
    ~ds2_byte0[nes_host_pkg::DS2_UP],
    ~ds2_byte0[nes_host_pkg::DS2_START],
    ~ds2_byte0[nes_host_pkg::DS2_SELECT],
    ~ds2_byte1[nes_host_pkg::DS2_CROSS],   // B
    ~ds2_byte1[nes_host_pkg::DS2_CIRCLE]   // A
  };

  assign clock_fall = last_clock && !joypad_clock;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      last_clock <= 1'b0;
    end else begin
      last_clock <= joypad_clock;
    end
  end

  // a falling edge wins over the strobe load
  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      shift_reg <= '0;
    end else if (clock_fall) begin
      shift_reg <= {1'b0, shift_reg[nes_host_pkg::BYTE_W-1:1]};  // zero fill
    end else if (joypad_strobe) begin
      shift_reg <= host_btn | pad_btn;
    end
  end

  assign joypad_data = shift_reg[0];

endmodule

// ==== verilog/nes_phase_sequencer.sv ====
// NES phase sequencer
// free running frame counter, one memory slot in phase 0 and
// one NES slot in the last phase, both held off until ROM load is done

`timescale 1ns/1ns

module nes_phase_sequencer #(
  parameter int PHASES = 5
) (
  input  logic clk,
  input  logic sys_resetn,
  input  logic loader_done,
  output logic run_mem,
  output logic run_nes,
  output logic reset_nes
);

  localparam int CNT_W = (PHASES > 1) ? $clog2(PHASES) : 1;
  localparam logic [CNT_W-1:0] LAST_PHASE = CNT_W'(PHASES - 1);

  logic [CNT_W-1:0] phase;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      phase <= '0;
    end else if (phase == LAST_PHASE) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  assign reset_nes = !loader_done;

  // memory command goes out first, NES samples read data
  // in the last phase, PHASES-1 cycles later
  assign run_mem = (phase == '0) && !reset_nes;
  assign run_nes = (phase == LAST_PHASE) && !reset_nes;

endmodule

// ==== verilog/mem_request_mux.sv ====
// Memory request multiplexer
// merges loader writes, NES accesses and refresh into the single
// request port of the memory controller, loader first

`timescale 1ns/1ns

module mem_request_mux (
  input  logic                            run_mem,
  input  logic [nes_host_pkg::ADDR_W-1:0] nes_addr,
  input  logic                            nes_read_cpu,
  input  logic                            nes_read_ppu,
  input  logic                            nes_write,
  input  logic [nes_host_pkg::BYTE_W-1:0] nes_wdata,
  input  logic [nes_host_pkg::ADDR_W-1:0] loader_addr,
  input  logic [nes_host_pkg::BYTE_W-1:0] loader_wdata,
  input  logic                            loader_write,
  input  logic                            loader_refresh,
  output logic                            mem_read_a,
  output logic                            mem_read_b,
  output logic                            mem_write,
  output logic                            mem_refresh,
  output logic [nes_host_pkg::ADDR_W-1:0] mem_addr,
  output logic [nes_host_pkg::BYTE_W-1:0] mem_din
);

  logic nes_req;
  logic idle_slot;

  assign nes_req = nes_read_cpu || nes_read_ppu || nes_write;

  // memory slot with nothing to do, keep the SDRAM refreshed
  assign idle_slot = run_mem && !nes_req && !loader_write;

  assign mem_read_a  = nes_read_cpu && run_mem;  // CPU port
  assign mem_read_b  = nes_read_ppu && run_mem;  // PPU port
  assign mem_write   = (nes_write && run_mem) || loader_write;
  assign mem_refresh = idle_slot || (loader_refresh && !loader_write);

  // loader owns the address and data whenever it writes
  always_comb begin
    if (loader_write) begin
      mem_addr = loader_addr;
      mem_din  = loader_wdata;
    end else begin
      mem_addr = nes_addr;
      mem_din  = nes_wdata;
    end
  end

endmodule

// ==== verilog/nes_host_top.sv ====
// NES host glue top level
// joins host register decode, the two joypad ports, the phase
// sequencer and the memory request mux between NES core, loader and SDRAM

`timescale 1ns/1ns

module nes_host_top (
  input  logic                            clk,
  input  logic                            sys_resetn,

  // host UART register writes
  input  logic [7:0]                      uart_addr,
  input  logic [nes_host_pkg::BYTE_W-1:0] uart_data,
  input  logic                            uart_write,

  // SD card ROM bytes
  input  logic [nes_host_pkg::BYTE_W-1:0] sd_dout,
  input  logic                            sd_dout_valid,

  // DualShock receive bytes, active low buttons
  input  logic [nes_host_pkg::BYTE_W-1:0] ds2a_byte0,
  input  logic [nes_host_pkg::BYTE_W-1:0] ds2a_byte1,
  input  logic [nes_host_pkg::BYTE_W-1:0] ds2b_byte0,
  input  logic [nes_host_pkg::BYTE_W-1:0] ds2b_byte1,

  // NES core side
  input  logic                            joypad_strobe,
  input  logic [1:0]                      joypad_clock,   // one per pad
  input  logic [nes_host_pkg::ADDR_W-1:0] nes_addr,
  input  logic                            nes_read_cpu,
  input  logic                            nes_read_ppu,
  input  logic                            nes_write,
  input  logic [nes_host_pkg::BYTE_W-1:0] nes_wdata,
  output logic [1:0]                      joypad_data,
  output logic                            reset_nes,
  output logic                            run_nes,

  // ROM loader side
  input  logic [nes_host_pkg::ADDR_W-1:0] loader_addr,
  input  logic [nes_host_pkg::BYTE_W-1:0] loader_wdata,
  input  logic                            loader_write,
  input  logic                            loader_refresh,
  input  logic                            loader_done,
  output logic [nes_host_pkg::BYTE_W-1:0] loader_input,
  output logic                            loader_clk,
  output logic                            loader_reset,

  // memory controller request
  output logic                            mem_read_a,
  output logic                            mem_read_b,
  output logic                            mem_write,
  output logic                            mem_refresh,
  output logic [nes_host_pkg::ADDR_W-1:0] mem_addr,
  output logic [nes_host_pkg::BYTE_W-1:0] mem_din
);

  logic [nes_host_pkg::BYTE_W-1:0] host_btn1;
  logic [nes_host_pkg::BYTE_W-1:0] host_btn2;
  logic                            run_mem;

  host_reg_decode u_decode (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .uart_addr     (uart_addr),
    .uart_data     (uart_data),
    .uart_write    (uart_write),
    .sd_dout       (sd_dout),
    .sd_dout_valid (sd_dout_valid),
    .loader_input  (loader_input),
    .loader_clk    (loader_clk),
    .loader_reset  (loader_reset),
    .host_btn1     (host_btn1),
    .host_btn2     (host_btn2)
  );

  joypad_port u_pad1 (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .ds2_byte0     (ds2a_byte0),
    .ds2_byte1     (ds2a_byte1),
    .host_btn      (host_btn1),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock[0]),
    .joypad_data   (joypad_data[0])
  );

  joypad_port u_pad2 (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .ds2_byte0     (ds2b_byte0),
    .ds2_byte1     (ds2b_byte1),
    .host_btn      (host_btn2),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock[1]),
    .joypad_data   (joypad_data[1])
  );

  nes_phase_sequencer #(
    .PHASES (nes_host_pkg::NES_CE_PHASES)
  ) u_phase (
    .clk         (clk),
    .sys_resetn  (sys_resetn),
    .loader_done (loader_done),
    .run_mem     (run_mem),
    .run_nes     (run_nes),
    .reset_nes   (reset_nes)
  );

  mem_request_mux u_mem_mux (
    .run_mem        (run_mem),
    .nes_addr       (nes_addr),
    .nes_read_cpu   (nes_read_cpu),
    .nes_read_ppu   (nes_read_ppu),
    .nes_write      (nes_write),
    .nes_wdata      (nes_wdata),
    .loader_addr    (loader_addr),
    .loader_wdata   (loader_wdata),
    .loader_write   (loader_write),
    .loader_refresh (loader_refresh),
    .mem_read_a     (mem_read_a),
    .mem_read_b     (mem_read_b),
    .mem_write      (mem_write),
    .mem_refresh    (mem_refresh),
    .mem_addr       (mem_addr),
    .mem_din        (mem_din)
  );

endmodule

// ==== tb/tb_clock_gen.sv ====
// Testbench clock and reset
// free running clk and a synchronous active-low reset for the first cycles

`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic sys_resetn
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    sys_resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    sys_resetn <= 1'b1;  // released on a rising edge
  end

endmodule

// ==== tb/nes_host_tb.sv ====
// NES host glue testbench
// drives the UART, SD, DualShock, NES and loader sides of the top level
// and checks loader stream, loader reset, joypad reads, phases and memory requests

`timescale 1ns/1ns

module nes_host_tb;

  localparam int CLK_PERIOD    = 100;
  localparam int RESET_CYCLES  = 3;
  localparam int FRAME         = nes_host_pkg::NES_CE_PHASES;
  localparam int STREAM_ROUNDS = 4;
  localparam int PAD_ROUNDS    = 4;
  localparam int MEM_CYCLES    = 30;
  localparam int AW            = nes_host_pkg::ADDR_W;

  // watchdog limit from the cycles each test takes
  localparam int TEST_CYCLES = RESET_CYCLES + 2 + STREAM_ROUNDS * 4 + 4
                               + PAD_ROUNDS * (1 + 2 * 2 + 2 + 8 * 3)
                               + 7 * FRAME + 1 + 3 * (MEM_CYCLES + 1);
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 100;

  logic clk;
  logic sys_resetn;
  logic [7:0] uart_addr;
  logic [7:0] uart_data;
  logic uart_write;
  logic [7:0] sd_dout;
  logic sd_dout_valid;
  logic [7:0] ds2a_byte0;
  logic [7:0] ds2a_byte1;
  logic [7:0] ds2b_byte0;
  logic [7:0] ds2b_byte1;
  logic joypad_strobe;
  logic [1:0] joypad_clock;
  logic [AW-1:0] nes_addr;
  logic nes_read_cpu;
  logic nes_read_ppu;
  logic nes_write;
  logic [7:0] nes_wdata;
  logic [1:0] joypad_data;
  logic reset_nes;
  logic run_nes;
  logic [AW-1:0] loader_addr;
  logic [7:0] loader_wdata;
  logic loader_write;
  logic loader_refresh;
  logic loader_done;
  logic [7:0] loader_input;
  logic loader_clk;
  logic loader_reset;
  logic mem_read_a;
  logic mem_read_b;
  logic mem_write;
  logic mem_refresh;
  logic [AW-1:0] mem_addr;
  logic [7:0] mem_din;

  int errors;
  int checks;
  logic [31:0] lcg_state;
  logic [31:0] cyc;  // cycles since reset track the frame phase

  tb_clock_gen #(
    .PERIOD       (CLK_PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clk (
    .clk        (clk),
    .sys_resetn (sys_resetn)
  );

  nes_host_top uut (.*);

  always @(posedge clk) begin
    if (!sys_resetn) begin
      cyc <= '0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // low LCG bits repeat too soon so only upper halves are kept
  task automatic rand_word(output logic [31:0] w);
    logic [15:0] hi;
    lcg_state = lcg_step(lcg_state);
    hi = lcg_state[31:16];
    lcg_state = lcg_step(lcg_state);
    w = {hi, lcg_state[31:16]};
  endtask

  task automatic host_write(input logic [7:0] addr, input logic [7:0] data);
    @(posedge clk);
    uart_addr  <= addr;
    uart_data  <= data;
    uart_write <= 1'b1;
    @(posedge clk);
    uart_write <= 1'b0;
  endtask

  // DualShock buttons are active low
  // NES order R L D U START SELECT B A
  function automatic logic [7:0] expected_buttons(input logic [7:0] b0, input logic [7:0] b1,
                                                  input logic [7:0] host);
    nes_host_pkg::host_reg_u pad;
    pad.btn.right  = !b0[nes_host_pkg::DS2_RIGHT];
    pad.btn.left   = !b0[nes_host_pkg::DS2_LEFT];
    pad.btn.down   = !b0[nes_host_pkg::DS2_DOWN];
    pad.btn.up     = !b0[nes_host_pkg::DS2_UP];
    pad.btn.start  = !b0[nes_host_pkg::DS2_START];
    pad.btn.select = !b0[nes_host_pkg::DS2_SELECT];
    pad.btn.b      = !b1[nes_host_pkg::DS2_CROSS];
    pad.btn.a      = !b1[nes_host_pkg::DS2_CIRCLE];
    return pad | host;
  endfunction

  task automatic stream_loader_bytes();
    logic [31:0] r;
    logic [7:0] sd_byte;
    for (int i = 0; i < STREAM_ROUNDS; i++) begin
      rand_word(r);
      sd_byte = ~r[7:0];  // always differs from the UART byte
      @(posedge clk);
      uart_addr  <= nes_host_pkg::LOADER_DATA_ADDR;
      uart_data  <= r[7:0];
      uart_write <= 1'b1;
      @(negedge clk);
      check_val("stream uart clk", 1, loader_clk);
      check_val("stream uart byte", r[7:0], loader_input);
      @(posedge clk);
      uart_addr <= i[0] ? 8'h36 : 8'h80;  // unmapped addresses
      @(negedge clk);
      check_val("stream other addr clk", 0, loader_clk);
      @(posedge clk);
      uart_addr     <= nes_host_pkg::LOADER_DATA_ADDR;
      sd_dout       <= sd_byte;
      sd_dout_valid <= 1'b1;
      @(negedge clk);
      check_val("stream sd clk", 1, loader_clk);
      check_val("stream sd byte", sd_byte, loader_input);
      @(posedge clk);
      uart_write    <= 1'b0;
      sd_dout_valid <= 1'b0;
    end
  endtask

  task automatic toggle_loader_reset();
    logic [31:0] r;
    rand_word(r);
    @(posedge clk);
    uart_addr  <= nes_host_pkg::LOADER_CONF_ADDR;
    uart_data  <= r[7:0] | 8'h01;
    uart_write <= 1'b1;
    @(negedge clk);
    check_val("loader reset same cycle", 0, loader_reset);
    @(posedge clk);
    uart_write <= 1'b0;
    @(negedge clk);
    check_val("loader reset set", 1, loader_reset);
    host_write(nes_host_pkg::LOADER_CONF_ADDR, r[15:8] & 8'hfe);
    @(negedge clk);
    check_val("loader reset cleared", 0, loader_reset);
  endtask

  task automatic read_joypads();
    logic [31:0] r;
    logic [31:0] h;
    logic [7:0] exp1;
    logic [7:0] exp2;
    for (int n = 0; n < PAD_ROUNDS; n++) begin
      rand_word(r);
      rand_word(h);
      @(posedge clk);
      ds2a_byte0 <= r[7:0];
      ds2a_byte1 <= r[15:8];
      ds2b_byte0 <= r[23:16];
      ds2b_byte1 <= r[31:24];
      host_write(nes_host_pkg::PAD1_BTN_ADDR, h[7:0]);
      host_write(nes_host_pkg::PAD2_BTN_ADDR, h[15:8]);
      exp1 = expected_buttons(r[7:0], r[15:8], h[7:0]);
      exp2 = expected_buttons(r[23:16], r[31:24], h[15:8]);
      @(posedge clk);
      joypad_strobe <= 1'b1;
      @(posedge clk);
      joypad_strobe <= 1'b0;
      @(negedge clk);
      check_val("pad1 bit 0", exp1[0], joypad_data[0]);
      check_val("pad2 bit 0", exp2[0], joypad_data[1]);
      for (int k = 1; k <= 8; k++) begin
        @(posedge clk);
        joypad_clock <= 2'b11;
        @(posedge clk);
        joypad_clock <= 2'b00;
        @(negedge clk);
        @(negedge clk);  // shift lands one cycle after the edge is seen
        check_val("pad1 shifted bit", (exp1 >> k) & 8'h01, joypad_data[0]);
        check_val("pad2 shifted bit", (exp2 >> k) & 8'h01, joypad_data[1]);
      end
    end
  endtask

  // with NES and loader idle mem_refresh marks the memory slot
  task automatic count_phases();
    int mem_pulses;
    int nes_pulses;
    logic seen_mem;
    logic [31:0] last_mem;
    mem_pulses = 0;
    nes_pulses = 0;
    seen_mem = 1'b0;
    last_mem = '0;
    repeat (2 * FRAME) begin
      @(negedge clk);
      check_val("phase held run_nes", 0, run_nes);
      check_val("phase held refresh", 0, mem_refresh);
      check_val("phase held reset_nes", 1, reset_nes);
    end
    @(posedge clk);
    loader_done <= 1'b1;
    repeat (5 * FRAME) begin
      @(negedge clk);
      check_val("phase reset_nes", 0, reset_nes);
      check_val("phase run_mem slot", (cyc % FRAME) == 0, mem_refresh);
      check_val("phase run_nes slot", (cyc % FRAME) == FRAME - 1, run_nes);
      if (mem_refresh) begin
        mem_pulses++;
        seen_mem = 1'b1;
        last_mem = cyc;
      end
      if (run_nes) begin
        nes_pulses++;
        if (seen_mem) begin
          check_val("phase mem to nes gap", FRAME - 1, cyc - last_mem);
        end
      end
    end
    check_val("phase run_mem count", 5, mem_pulses);
    check_val("phase run_nes count", 5, nes_pulses);
  endtask

  // mode 0 loader writes, mode 1 NES only, mode 2 loader refresh
  task automatic drive_mem_requests(input int mode, input string tag);
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic run;
    logic nes_any;
    logic exp_write;
    logic exp_refresh;
    logic [AW-1:0] exp_addr;
    logic [7:0] exp_din;
    for (int i = 0; i < MEM_CYCLES; i++) begin
      rand_word(r);
      rand_word(a);
      rand_word(b);
      @(posedge clk);
      nes_addr       <= a[AW-1:0];
      nes_wdata      <= r[7:0];
      nes_read_cpu   <= (mode == 2) ? 1'b0 : r[8] & r[12];
      nes_read_ppu   <= (mode == 2) ? 1'b0 : r[9] & r[13];
      nes_write      <= (mode == 2) ? 1'b0 : r[10] & r[14];
      loader_addr    <= b[AW-1:0];
      loader_wdata   <= r[23:16];
      loader_write   <= (mode == 0);
      loader_refresh <= (mode == 2) ? 1'b1 : (mode == 0) ? r[11] : 1'b0;
      @(negedge clk);
      run = (cyc % FRAME) == 0;
      nes_any = nes_read_cpu || nes_read_ppu || nes_write;
      case (mode)
        0: begin  // loader owns the port
          exp_write   = 1'b1;
          exp_refresh = 1'b0;
          exp_addr    = b[AW-1:0];
          exp_din     = r[23:16];
        end
        1: begin
          exp_write   = nes_write && run;
          exp_refresh = run && !nes_any;  // idle memory slot
          exp_addr    = a[AW-1:0];
          exp_din     = r[7:0];
        end
        default: begin
          exp_write   = 1'b0;
          exp_refresh = 1'b1;
          exp_addr    = a[AW-1:0];
          exp_din     = r[7:0];
        end
      endcase
      check_val({tag, " read_a"}, nes_read_cpu && run, mem_read_a);
      check_val({tag, " read_b"}, nes_read_ppu && run, mem_read_b);
      check_val({tag, " write"}, exp_write, mem_write);
      check_val({tag, " refresh"}, exp_refresh, mem_refresh);
      check_val({tag, " addr"}, exp_addr, mem_addr);
      check_val({tag, " din"}, exp_din, mem_din);
    end
    @(posedge clk);
    nes_read_cpu   <= 1'b0;
    nes_read_ppu   <= 1'b0;
    nes_write      <= 1'b0;
    loader_write   <= 1'b0;
    loader_refresh <= 1'b0;
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    errors = 0;
    checks = 0;
    lcg_state = 32'd90346;
    uart_addr = '0;
    uart_data = '0;
    uart_write = 1'b0;
    sd_dout = '0;
    sd_dout_valid = 1'b0;
    ds2a_byte0 = 8'hff;  // nothing pressed
    ds2a_byte1 = 8'hff;
    ds2b_byte0 = 8'hff;
    ds2b_byte1 = 8'hff;
    joypad_strobe = 1'b0;
    joypad_clock = 2'b00;
    nes_addr = '0;
    nes_read_cpu = 1'b0;
    nes_read_ppu = 1'b0;
    nes_write = 1'b0;
    nes_wdata = '0;
    loader_addr = '0;
    loader_wdata = '0;
    loader_write = 1'b0;
    loader_refresh = 1'b0;
    loader_done = 1'b0;
    @(negedge clk);
    check_val("reset loader_reset", 1, loader_reset);
    wait (sys_resetn === 1'b1);
    @(negedge clk);
    check_val("reset joypad_data", 0, joypad_data);
    check_val("reset loader_reset released", 0, loader_reset);
    stream_loader_bytes();
    toggle_loader_reset();
    read_joypads();
    count_phases();
    drive_mem_requests(0, "mem loader");
    drive_mem_requests(1, "mem nes");
    drive_mem_requests(2, "mem refresh");
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== list.f ====
verilog/nes_host_pkg.sv
verilog/host_reg_decode.sv
verilog/joypad_port.sv
verilog/nes_phase_sequencer.sv
verilog/mem_request_mux.sv
verilog/nes_host_top.sv
tb/tb_clock_gen.sv
tb/nes_host_tb.sv

// ==== Makefile ====
# Verilator build and run of the NES host glue testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = nes_host_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
PASS_MSG = Finished with no errors

SRCS = $(wildcard verilog/*.sv) $(wildcard tb/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
